//--- id_stage.f
common/id_pkg.sv
decode/inst_decoder.sv
decode/regfile.sv
decode/operand_forward.sv
decode/branch_resolve.sv
rtl/id_stage.sv
dv/tb_clock.sv
dv/id_checker.sv
dv/tb_id_stage.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --top-module tb_id_stage -f id_stage.f -o sim_id_stage
./obj_dir/sim_id_stage | tee sim.log
if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

//--- dv/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage import id_pkg::*; ();

localparam int N_XFER = 2000;
localparam int CLK_NS = 8;

localparam logic [16:0] OPS_3R [11] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
                                       OP_OR, OP_XOR, OP_SLL_W, OP_SRL_W, OP_SRA_W};
localparam logic [16:0] OPS_SHI [3] = '{OP_SLLI_W, OP_SRLI_W, OP_SRAI_W};
localparam logic [9:0]  OPS_I12 [6] = '{OP_SLTI, OP_SLTUI, OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI};
localparam logic [9:0]  OPS_MEM [8] = '{OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
                                       OP_ST_B, OP_ST_H, OP_ST_W};
localparam logic [6:0]  OPS_U20 [2] = '{OP_LU12I_W, OP_PCADDU12I};
localparam logic [5:0]  OPS_BR [9]  = '{OP_JIRL, OP_B, OP_BL, OP_BEQ, OP_BNE, OP_BLT,
                                       OP_BGE, OP_BLTU, OP_BGEU};

logic          clk;
logic          rst_n;
logic          flush;
logic          fs_valid;
fetch_bundle_t fs_bundle;
logic          ds_allowin;
logic          ds_to_es_valid;
ds_to_es_t     ds_to_es;
logic          es_allowin;
fwd_bus_t      es_fwd;
fwd_bus_t      ms_fwd;
wb_bus_t       wb;
redirect_t     redirect;
logic [15:0]   lfsr;
logic [31:0]   pc_next;
int            transfers;
int            redirects;
int            errors;

tb_clock clock_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
);

id_stage dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .fs_valid       (fs_valid),
    .fs_bundle      (fs_bundle),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es       (ds_to_es),
    .es_allowin     (es_allowin),
    .es_fwd         (es_fwd),
    .ms_fwd         (ms_fwd),
    .wb             (wb),
    .redirect       (redirect)
);

id_checker checker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .fs_valid       (fs_valid),
    .fs_bundle      (fs_bundle),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es       (ds_to_es),
    .es_allowin     (es_allowin),
    .es_fwd         (es_fwd),
    .ms_fwd         (ms_fwd),
    .wb             (wb),
    .redirect       (redirect),
    .transfers      (transfers),
    .redirects      (redirects),
    .errors         (errors)
);

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr[0]};
        lfsr = lfsr_step(lfsr);
    end
    return v;
endfunction

function automatic fwd_bus_t random_fwd();
    fwd_bus_t f;
    f.en         = take_bits(1) == 1;
    f.need_stall = take_bits(2) == 0;
    f.dest       = 5'(take_bits(3));
    f.data       = take_bits(32);
    return f;
endfunction

// registers limited to r0..r7 so that forwarding hits are common
function automatic fetch_bundle_t make_fetch(input logic [31:0] pc);
    fetch_bundle_t f;
    logic [4:0]    rd;
    logic [4:0]    rj;
    logic [4:0]    rk;
    logic [25:0]   offs;
    logic [31:0]   off;
    logic [5:0]    bop;
    int            k;
    rd   = 5'(take_bits(3));
    rj   = 5'(take_bits(3));
    rk   = 5'(take_bits(3));
    offs = 26'(take_bits(26));
    off  = 32'd0;
    k    = take_bits(3);
    case (k)
        0: f.inst = {OPS_3R[4'(take_bits(4) % 11)], rk, rj, rd};
        1: f.inst = {OPS_SHI[2'(take_bits(2) % 3)], rk, rj, rd};
        2: f.inst = {OPS_I12[3'(take_bits(3) % 6)], 12'(take_bits(12)), rj, rd};
        3: f.inst = {OPS_MEM[3'(take_bits(3))], 12'(take_bits(12)), rj, rd};
        4: f.inst = {OPS_U20[1'(take_bits(1))], 20'(take_bits(20)), rd};
        5, 6: begin
            bop = OPS_BR[4'(take_bits(4) % 9)];
            if (bop == OP_B || bop == OP_BL) begin
                f.inst = {bop, offs[15:0], offs[25:16]};
                off    = {{4{offs[25]}}, offs, 2'b00};
            end else begin
                f.inst = {bop, offs[15:0], rj, rd};
                off    = {{14{offs[15]}}, offs[15:0], 2'b00};
            end
        end
        default: f.inst = take_bits(32);
    endcase
    f.pc          = pc;
    f.pred_taken  = take_bits(1) == 1;
    f.pred_target = (take_bits(1) == 1) ? pc + off : take_bits(32);
    return f;
endfunction

task automatic drive_random();
    fs_valid   = take_bits(2) != 0;
    fs_bundle  = make_fetch(pc_next);
    pc_next    = pc_next + 32'd4;
    es_allowin = take_bits(2) != 0;
    flush      = take_bits(6) == 0;
    es_fwd     = random_fwd();
    ms_fwd     = random_fwd();
    wb.we      = take_bits(1) == 1;
    wb.waddr   = 5'(take_bits(3));
    wb.wdata   = take_bits(32);
endtask

initial begin
    flush      = 1'b0;
    fs_valid   = 1'b0;
    fs_bundle  = '0;
    es_allowin = 1'b1;
    es_fwd     = '0;
    ms_fwd     = '0;
    wb         = '0;
    lfsr       = 16'd55406;
    pc_next    = 32'h1c00_0000;
    // fill every register once so that no read returns an unknown
    for (int r = 1; r < 32; r++) begin
        @(posedge clk);
        #1;
        wb.we    = 1'b1;
        wb.waddr = 5'(r);
        wb.wdata = take_bits(32);
    end
    @(posedge clk);
    #1;
    wb = '0;
    while (!rst_n) begin
        @(posedge clk);
    end
    while (transfers < N_XFER) begin
        @(posedge clk);
        #1;
        drive_random();
    end
    $display("transfers %0d, redirects %0d, errors %0d", transfers, redirects, errors);
    if (errors == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

initial begin
    #(20 * N_XFER * CLK_NS);
    $display("timeout: only %0d of %0d transfers done, errors %0d", transfers, N_XFER, errors);
    $display("SIMULATION FAILED");
    $finish;
end

endmodule

//--- dv/id_checker.sv
`timescale 1ns/1ns

module id_checker import id_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          fs_valid,
    input  fetch_bundle_t fs_bundle,
    input  logic          ds_allowin,
    input  logic          ds_to_es_valid,
    input  ds_to_es_t     ds_to_es,
    input  logic          es_allowin,
    input  fwd_bus_t      es_fwd,
    input  fwd_bus_t      ms_fwd,
    input  wb_bus_t       wb,
    input  redirect_t     redirect,
    output int            transfers,
    output int            redirects,
    output int            errors
);

// instruction classes
localparam int CL_INE   = 0;
localparam int CL_REG3  = 1;
localparam int CL_SHIFT = 2;
localparam int CL_SI12  = 3;
localparam int CL_UI12  = 4;
localparam int CL_LOAD  = 5;
localparam int CL_STORE = 6;
localparam int CL_LU12I = 7;
localparam int CL_PCADD = 8;
localparam int CL_BCC   = 9;
localparam int CL_B     = 10;
localparam int CL_BL    = 11;
localparam int CL_JIRL  = 12;

logic [XLEN-1:0] shadow [32];
fetch_bundle_t   pend [$];
logic            cancel_next;

initial begin
    shadow[0]   = '0;
    cancel_next = 1'b0;
    transfers   = 0;
    redirects   = 0;
    errors      = 0;
end

function automatic int inst_class(input logic [31:0] w);
    if (w[31:15] inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
                         OP_OR, OP_XOR, OP_SLL_W, OP_SRL_W, OP_SRA_W})
        return CL_REG3;
    if (w[31:15] inside {OP_SLLI_W, OP_SRLI_W, OP_SRAI_W})
        return CL_SHIFT;
    if (w[31:22] inside {OP_SLTI, OP_SLTUI, OP_ADDI_W})
        return CL_SI12;
    if (w[31:22] inside {OP_ANDI, OP_ORI, OP_XORI})
        return CL_UI12;
    if (w[31:22] inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU})
        return CL_LOAD;
    if (w[31:22] inside {OP_ST_B, OP_ST_H, OP_ST_W})
        return CL_STORE;
    if (w[31:25] == OP_LU12I_W)
        return CL_LU12I;
    if (w[31:25] == OP_PCADDU12I)
        return CL_PCADD;
    if (w[31:26] inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU})
        return CL_BCC;
    if (w[31:26] == OP_B)
        return CL_B;
    if (w[31:26] == OP_BL)
        return CL_BL;
    if (w[31:26] == OP_JIRL)
        return CL_JIRL;
    return CL_INE;
endfunction

function automatic alu_op_e alu_of(input logic [31:0] w);
    case (w[31:15])
        OP_SUB_W:            return ALU_SUB;
        OP_SLT:              return ALU_SLT;
        OP_SLTU:             return ALU_SLTU;
        OP_AND:              return ALU_AND;
        OP_OR:               return ALU_OR;
        OP_NOR:              return ALU_NOR;
        OP_XOR:              return ALU_XOR;
        OP_SLL_W, OP_SLLI_W: return ALU_SLL;
        OP_SRL_W, OP_SRLI_W: return ALU_SRL;
        OP_SRA_W, OP_SRAI_W: return ALU_SRA;
        default:             ;
    endcase
    case (w[31:22])
        OP_SLTI:  return ALU_SLT;
        OP_SLTUI: return ALU_SLTU;
        OP_ANDI:  return ALU_AND;
        OP_ORI:   return ALU_OR;
        OP_XORI:  return ALU_XOR;
        default:  ;
    endcase
    return (w[31:25] == OP_LU12I_W) ? ALU_LUI : ALU_ADD;
endfunction

function automatic br_kind_e branch_of(input logic [31:0] w);
    case (w[31:26])
        OP_BEQ:  return BR_BEQ;
        OP_BNE:  return BR_BNE;
        OP_BLT:  return BR_BLT;
        OP_BGE:  return BR_BGE;
        OP_BLTU: return BR_BLTU;
        OP_BGEU: return BR_BGEU;
        OP_B:    return BR_B;
        OP_BL:   return BR_BL;
        OP_JIRL: return BR_JIRL;
        default: return BR_NONE;
    endcase
endfunction

task automatic decode_ref(
    input  logic [31:0] w,
    output ds_to_es_t   e,
    output logic        use_rj,
    output logic        use_rkd,
    output logic        rd_src
);
    int cls;
    cls           = inst_class(w);
    e             = '0;
    e.alu_op      = alu_of(w);
    e.dest        = (cls == CL_BL) ? 5'd1 : w[4:0];
    e.ine         = (cls == CL_INE);
    use_rj        = cls inside {CL_REG3, CL_SHIFT, CL_SI12, CL_UI12, CL_LOAD, CL_STORE,
                                CL_BCC, CL_JIRL};
    use_rkd       = cls inside {CL_REG3, CL_STORE, CL_BCC};
    rd_src        = cls inside {CL_STORE, CL_BCC};
    e.gr_we       = cls inside {CL_REG3, CL_SHIFT, CL_SI12, CL_UI12, CL_LOAD, CL_LU12I,
                                CL_PCADD, CL_BL, CL_JIRL};
    e.src2_is_imm = cls inside {CL_SHIFT, CL_SI12, CL_UI12, CL_LOAD, CL_STORE, CL_LU12I,
                                CL_PCADD};
    e.src1_is_pc  = cls inside {CL_PCADD, CL_BL, CL_JIRL};
    e.src2_is_4   = cls inside {CL_BL, CL_JIRL};
    e.load        = (cls == CL_LOAD);
    e.store       = (cls == CL_STORE);
    if (e.load || e.store) begin
        case (w[31:22])
            OP_LD_B, OP_LD_BU, OP_ST_B: e.mem_size = 2'b01;
            OP_LD_H, OP_LD_HU, OP_ST_H: e.mem_size = 2'b10;
            default:                    e.mem_size = 2'b00;
        endcase
        e.mem_signed = w[31:22] inside {OP_LD_B, OP_LD_H};
    end
    case (cls)
        CL_SHIFT:                   e.imm = {27'd0, w[14:10]};
        CL_SI12, CL_LOAD, CL_STORE: e.imm = {{20{w[21]}}, w[21:10]};
        CL_UI12:                    e.imm = {20'd0, w[21:10]};
        CL_LU12I, CL_PCADD:         e.imm = {w[24:5], 12'd0};
        CL_BCC, CL_JIRL:            e.imm = {{14{w[25]}}, w[25:10], 2'b00};
        CL_B, CL_BL:                e.imm = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        default:                    e.imm = '0;
    endcase
endtask

// execute beats memory beats the register file
task automatic source_value(
    input  logic [4:0]  a,
    input  logic        need,
    input  logic        reg_br,
    output logic [31:0] v,
    output logic        stall
);
    stall = 1'b0;
    v     = (a == 5'd0) ? 32'd0 : shadow[a];
    if (need && a != 5'd0) begin
        if (es_fwd.en && es_fwd.dest == a) begin
            v     = es_fwd.data;
            stall = es_fwd.need_stall;
        end else if (ms_fwd.en && ms_fwd.dest == a) begin
            v     = ms_fwd.data;
            stall = ms_fwd.need_stall || reg_br;
        end
    end
endtask

task automatic check_cycle();
    fetch_bundle_t head;
    ds_to_es_t     exp;
    br_kind_e      kind;
    logic          use_rj;
    logic          use_rkd;
    logic          rd_src;
    logic          reg_br;
    logic          st1;
    logic          st2;
    logic          go;
    logic          xfer;
    logic          taken;
    logic          exp_redir;
    logic [31:0]   tgt;
    logic [31:0]   exp_tgt;
    go        = 1'b1;
    taken     = 1'b0;
    exp_redir = 1'b0;
    exp_tgt   = '0;
    xfer      = ds_to_es_valid && es_allowin;
    if (pend.size() > 0) begin
        head = pend[0];
        kind = branch_of(head.inst);
        decode_ref(head.inst, exp, use_rj, use_rkd, rd_src);
        reg_br = (kind != BR_NONE) && use_rj;
        source_value(head.inst[9:5], use_rj, reg_br, exp.rj_value, st1);
        source_value(rd_src ? head.inst[4:0] : head.inst[14:10], use_rkd, reg_br,
                     exp.rkd_value, st2);
        exp.pc = head.pc;
        go     = exp.ine || !(st1 || st2);
        case (kind)
            BR_BEQ:               taken = exp.rj_value == exp.rkd_value;
            BR_BNE:               taken = exp.rj_value != exp.rkd_value;
            BR_BLT:               taken = $signed(exp.rj_value) < $signed(exp.rkd_value);
            BR_BGE:               taken = $signed(exp.rj_value) >= $signed(exp.rkd_value);
            BR_BLTU:              taken = exp.rj_value < exp.rkd_value;
            BR_BGEU:              taken = exp.rj_value >= exp.rkd_value;
            BR_B, BR_BL, BR_JIRL: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
        tgt     = ((kind == BR_JIRL) ? exp.rj_value : head.pc) + exp.imm;
        exp_tgt = taken ? tgt : head.pc + 32'd4;
        exp_redir = xfer && go && kind != BR_NONE && !exp.ine &&
                    ((taken != head.pred_taken) || (taken && tgt != head.pred_target));
    end
    if (ds_to_es_valid !== (pend.size() > 0 && go)) begin
        $display("MISMATCH %0t ns: ds_to_es_valid %b, pending %0d, ready %b",
                 $time, ds_to_es_valid, pend.size(), go);
        errors++;
    end
    if (ds_allowin !== (pend.size() == 0 || (go && es_allowin))) begin
        $display("MISMATCH %0t ns: ds_allowin %b, pending %0d", $time, ds_allowin, pend.size());
        errors++;
    end
    if (xfer) begin
        transfers++;
    end
    if (xfer && pend.size() > 0) begin
        if (ds_to_es !== exp) begin
            $display("MISMATCH %0t ns: bundle for pc %h got %h expected %h",
                     $time, head.pc, ds_to_es, exp);
            errors++;
        end
        pend.pop_front();
    end
    if (redirect.valid !== exp_redir) begin
        $display("MISMATCH %0t ns: redirect.valid %b expected %b", $time, redirect.valid,
                 exp_redir);
        errors++;
    end else if (exp_redir && redirect.target !== exp_tgt) begin
        $display("MISMATCH %0t ns: redirect target %h expected %h", $time, redirect.target,
                 exp_tgt);
        errors++;
    end
    if (exp_redir) begin
        redirects++;
    end
    // acceptance, with the wrong-path slot dropped after a redirect
    if (fs_valid && ds_allowin && !flush) begin
        if (exp_redir) begin
        end else if (cancel_next) begin
            cancel_next = 1'b0;
        end else begin
            pend.push_back(fs_bundle);
        end
    end
    if (exp_redir && !fs_valid) begin
        cancel_next = 1'b1;
    end
    if (flush) begin
        pend.delete();
        cancel_next = 1'b0;
    end
endtask

// inputs change 1 ns after the rising edge, so the falling edge sees a settled cycle
always @(negedge clk) begin
    if (!rst_n) begin
        pend.delete();
        cancel_next = 1'b0;
    end else begin
        check_cycle();
    end
    if (wb.we && wb.waddr != 5'd0) begin
        shadow[wb.waddr] = wb.wdata;
    end
end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// reset held for 16 rising edges
initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
end

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ns

module id_stage import id_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          fs_valid,
    input  fetch_bundle_t fs_bundle,
    output logic          ds_allowin,
    output logic          ds_to_es_valid,
    output ds_to_es_t     ds_to_es,
    input  logic          es_allowin,
    input  fwd_bus_t      es_fwd,
    input  fwd_bus_t      ms_fwd,
    input  wb_bus_t       wb,
    output redirect_t     redirect
);

logic              ds_valid;
fetch_bundle_t     ds_bundle;
logic              slot_cancel;
logic              ready_go;
logic              fs_accept;
dec_ctrl_t         ctrl;
logic [XLEN-1:0]   imm;
logic [REG_AW-1:0] raddr1;
logic [REG_AW-1:0] raddr2;
logic [XLEN-1:0]   rf_rdata1;
logic [XLEN-1:0]   rf_rdata2;
logic [XLEN-1:0]   rj_value;
logic [XLEN-1:0]   rkd_value;
logic              is_reg_branch;
logic              dep_stall;
logic              br_taken;
logic              br_mispredict;
logic [XLEN-1:0]   br_target;

// an undefined instruction goes on to execute without waiting
assign ready_go       = ctrl.ine || !dep_stall;
assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
assign ds_to_es_valid = ds_valid && ready_go;
assign fs_accept      = fs_valid && ds_allowin;

always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
        ds_valid <= 1'b0;
    end else if (ds_allowin) begin
        // wrong-path fetch behind a redirect is dropped here
        ds_valid <= fs_valid && !redirect.valid && !slot_cancel;
    end
end

always_ff @(posedge clk) begin
    if (fs_accept) begin
        ds_bundle <= fs_bundle;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
        slot_cancel <= 1'b0;
    end else if (redirect.valid && !fs_valid) begin
        slot_cancel <= 1'b1;
    end else if (slot_cancel && fs_accept) begin
        slot_cancel <= 1'b0;
    end
end

assign raddr1 = ds_bundle.inst[9:5];
assign raddr2 = ctrl.src_reg_is_rd ? ds_bundle.inst[4:0] : ds_bundle.inst[14:10];

assign is_reg_branch = (ctrl.br_kind != BR_NONE) && ctrl.need_rj;

inst_decoder u_decoder (
    .inst (ds_bundle.inst),
    .ctrl (ctrl),
    .imm  (imm)
);

regfile u_regfile (
    .clk    (clk),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wb     (wb)
);

operand_forward u_forward (
    .raddr1        (raddr1),
    .raddr2        (raddr2),
    .need_rj       (ctrl.need_rj),
    .need_rkd      (ctrl.need_rkd),
    .is_reg_branch (is_reg_branch),
    .rf_rdata1     (rf_rdata1),
    .rf_rdata2     (rf_rdata2),
    .es_fwd        (es_fwd),
    .ms_fwd        (ms_fwd),
    .rj_value      (rj_value),
    .rkd_value     (rkd_value),
    .dep_stall     (dep_stall)
);

branch_resolve u_branch (
    .br_kind     (ctrl.br_kind),
    .pc          (ds_bundle.pc),
    .imm         (imm),
    .rj_value    (rj_value),
    .rkd_value   (rkd_value),
    .pred_taken  (ds_bundle.pred_taken),
    .pred_target (ds_bundle.pred_target),
    .taken       (br_taken),
    .mispredict  (br_mispredict),
    .target      (br_target)
);

// redirect only fires together with the branch's transfer
assign redirect.valid  = ds_to_es_valid && es_allowin &&
                         (ctrl.br_kind != BR_NONE) && br_mispredict;
assign redirect.target = br_taken ? br_target : ds_bundle.pc + 32'd4;

always_comb begin
    ds_to_es.pc          = ds_bundle.pc;
    ds_to_es.imm         = imm;
    ds_to_es.rj_value    = rj_value;
    ds_to_es.rkd_value   = rkd_value;
    ds_to_es.alu_op      = ctrl.alu_op;
    ds_to_es.src1_is_pc  = ctrl.src1_is_pc;
    ds_to_es.src2_is_imm = ctrl.src2_is_imm;
    ds_to_es.src2_is_4   = ctrl.src2_is_4;
    ds_to_es.load        = ctrl.load;
    ds_to_es.store       = ctrl.store;
    ds_to_es.mem_size    = ctrl.mem_size;
    ds_to_es.mem_signed  = ctrl.mem_signed;
    ds_to_es.gr_we       = ctrl.gr_we;
    ds_to_es.dest        = ctrl.dest;
    ds_to_es.ine         = ctrl.ine;
end

endmodule

//--- decode/branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve import id_pkg::*; (
    input  br_kind_e        br_kind,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    input  logic            pred_taken,
    input  logic [XLEN-1:0] pred_target,
    output logic            taken,
    output logic            mispredict,
    output logic [XLEN-1:0] target
);

logic eq;
logic lt_s;
logic lt_u;

assign eq   = (rj_value == rkd_value);
assign lt_u = (rj_value < rkd_value);
assign lt_s = ($signed(rj_value) < $signed(rkd_value));

always_comb begin
    case (br_kind)
        BR_BEQ:               taken = eq;
        BR_BNE:               taken = !eq;
        BR_BLT:               taken = lt_s;
        BR_BGE:               taken = !lt_s;
        BR_BLTU:              taken = lt_u;
        BR_BGEU:              taken = !lt_u;
        BR_B, BR_BL, BR_JIRL: taken = 1'b1;
        default:              taken = 1'b0;
    endcase
end

// jirl is register relative
assign target = ((br_kind == BR_JIRL) ? rj_value : pc) + imm;

// wrong direction, or right direction with a stale target
assign mispredict = (taken != pred_taken) ||
                    (taken && pred_taken && target != pred_target);

endmodule

//--- decode/operand_forward.sv
`timescale 1ns/1ns

module operand_forward import id_pkg::*; (
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    input  logic              need_rj,
    input  logic              need_rkd,
    input  logic              is_reg_branch,
    input  logic [XLEN-1:0]   rf_rdata1,
    input  logic [XLEN-1:0]   rf_rdata2,
    input  fwd_bus_t          es_fwd,
    input  fwd_bus_t          ms_fwd,
    output logic [XLEN-1:0]   rj_value,
    output logic [XLEN-1:0]   rkd_value,
    output logic              dep_stall
);

logic rj_stall;
logic rkd_stall;

// returns {stall, value} for one source
function automatic logic [XLEN:0] pick(
    input logic [REG_AW-1:0] addr,
    input logic              need,
    input logic [XLEN-1:0]   rf_data
);
    logic [XLEN:0] res;
    res = {1'b0, rf_data};
    if (need && addr != '0) begin
        if (es_fwd.en && es_fwd.dest == addr) begin
            res = {es_fwd.need_stall, es_fwd.data};
        end else if (ms_fwd.en && ms_fwd.dest == addr) begin
            // branch compare cannot absorb the memory path in time
            res = {ms_fwd.need_stall || is_reg_branch, ms_fwd.data};
        end
    end
    return res;
endfunction

// forward buses are read inside pick as well as through its arguments
always_comb begin
    {rj_stall, rj_value}   = pick(raddr1, need_rj, rf_rdata1);
    {rkd_stall, rkd_value} = pick(raddr2, need_rkd, rf_rdata2);
end

assign dep_stall = rj_stall || rkd_stall;

endmodule

//--- decode/regfile.sv
`timescale 1ns/1ns

module regfile import id_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    input  wb_bus_t           wb
);

logic [XLEN-1:0] regs [2**REG_AW];

always_ff @(posedge clk) begin
    if (wb.we && wb.waddr != '0) begin
        regs[wb.waddr] <= wb.wdata;
    end
end

// r0 reads zero, reads see the value before a same-cycle write
assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- decode/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import id_pkg::*; (
    input  logic [31:0] inst,
    output dec_ctrl_t   ctrl,
    output logic [31:0] imm
);

typedef enum logic [3:0] {
    F_INE, F_3R, F_SHI, F_SI12, F_UI12, F_LOAD, F_STORE,
    F_LU12I, F_PCADD, F_BCC, F_B, F_BL, F_JIRL
} fmt_e;

fmt_e        fmt;
alu_op_e     op;
br_kind_e    kind;
logic [4:0]  rd;
logic [11:0] i12;
logic [15:0] i16;
logic [19:0] i20;
logic [25:0] i26;
logic [1:0]  mem_size;
logic        ld_signed;

assign rd  = inst[4:0];
assign i12 = inst[21:10];
assign i16 = inst[25:10];
assign i20 = inst[24:5];
assign i26 = {inst[9:0], inst[25:10]};

// size lives in inst[23:22] for every load and store
assign mem_size  = {inst[23:22] == 2'd1, inst[23:22] == 2'd0};
assign ld_signed = !inst[25] && (inst[23:22] != 2'd2);

always_comb begin
    case (inst[31:26])
        OP_JIRL: kind = BR_JIRL;
        OP_B:    kind = BR_B;
        OP_BL:   kind = BR_BL;
        OP_BEQ:  kind = BR_BEQ;
        OP_BNE:  kind = BR_BNE;
        OP_BLT:  kind = BR_BLT;
        OP_BGE:  kind = BR_BGE;
        OP_BLTU: kind = BR_BLTU;
        OP_BGEU: kind = BR_BGEU;
        default: kind = BR_NONE;
    endcase
end

always_comb begin
    if (inst[31:15] inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
                            OP_OR, OP_XOR, OP_SLL_W, OP_SRL_W, OP_SRA_W})
        fmt = F_3R;
    else if (inst[31:15] inside {OP_SLLI_W, OP_SRLI_W, OP_SRAI_W})
        fmt = F_SHI;
    else if (inst[31:22] inside {OP_SLTI, OP_SLTUI, OP_ADDI_W})
        fmt = F_SI12;
    else if (inst[31:22] inside {OP_ANDI, OP_ORI, OP_XORI})
        fmt = F_UI12;
    else if (inst[31:22] inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU})
        fmt = F_LOAD;
    else if (inst[31:22] inside {OP_ST_B, OP_ST_H, OP_ST_W})
        fmt = F_STORE;
    else if (inst[31:25] == OP_LU12I_W)
        fmt = F_LU12I;
    else if (inst[31:25] == OP_PCADDU12I)
        fmt = F_PCADD;
    else if (kind == BR_B)
        fmt = F_B;
    else if (kind == BR_BL)
        fmt = F_BL;
    else if (kind == BR_JIRL)
        fmt = F_JIRL;
    else if (kind != BR_NONE)
        fmt = F_BCC;
    else
        fmt = F_INE;
end

// loads, stores, pcaddu12i and the linking branches all add
always_comb begin
    op = ALU_ADD;
    case (inst[31:15])
        OP_SUB_W:            op = ALU_SUB;
        OP_SLT:              op = ALU_SLT;
        OP_SLTU:             op = ALU_SLTU;
        OP_NOR:              op = ALU_NOR;
        OP_AND:              op = ALU_AND;
        OP_OR:               op = ALU_OR;
        OP_XOR:              op = ALU_XOR;
        OP_SLL_W, OP_SLLI_W: op = ALU_SLL;
        OP_SRL_W, OP_SRLI_W: op = ALU_SRL;
        OP_SRA_W, OP_SRAI_W: op = ALU_SRA;
        default:             ;
    endcase
    case (inst[31:22])
        OP_SLTI:  op = ALU_SLT;
        OP_SLTUI: op = ALU_SLTU;
        OP_ANDI:  op = ALU_AND;
        OP_ORI:   op = ALU_OR;
        OP_XORI:  op = ALU_XOR;
        default:  ;
    endcase
    if (inst[31:25] == OP_LU12I_W) begin
        op = ALU_LUI;
    end
end

always_comb begin
    case (fmt)
        F_SHI:                   imm = {27'b0, inst[14:10]};
        F_SI12, F_LOAD, F_STORE: imm = {{20{i12[11]}}, i12};
        F_UI12:                  imm = {20'b0, i12};
        F_LU12I, F_PCADD:        imm = {i20, 12'b0};
        F_BCC, F_JIRL:           imm = {{14{i16[15]}}, i16, 2'b0};
        F_B, F_BL:               imm = {{4{i26[25]}}, i26, 2'b0};
        default:                 imm = '0;
    endcase
end

always_comb begin
    ctrl         = '0;
    ctrl.alu_op  = op;
    ctrl.dest    = rd;
    ctrl.br_kind = kind;
    ctrl.ine     = (fmt == F_INE);
    case (fmt)
        F_3R: begin
            ctrl.need_rj  = 1'b1;
            ctrl.need_rkd = 1'b1;
            ctrl.gr_we    = 1'b1;
        end
        F_SHI, F_SI12, F_UI12, F_LOAD: begin
            ctrl.need_rj     = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            ctrl.gr_we       = 1'b1;
            ctrl.load        = (fmt == F_LOAD);
            ctrl.mem_size    = (fmt == F_LOAD) ? mem_size : 2'b00;
            ctrl.mem_signed  = (fmt == F_LOAD) && ld_signed;
        end
        F_STORE: begin
            ctrl.need_rj       = 1'b1;
            ctrl.need_rkd      = 1'b1;
            ctrl.src_reg_is_rd = 1'b1;
            ctrl.src2_is_imm   = 1'b1;
            ctrl.store         = 1'b1;
            ctrl.mem_size      = mem_size;
        end
        F_LU12I, F_PCADD: begin
            ctrl.src1_is_pc  = (fmt == F_PCADD);
            ctrl.src2_is_imm = 1'b1;
            ctrl.gr_we       = 1'b1;
        end
        F_BCC: begin
            ctrl.need_rj       = 1'b1;
            ctrl.need_rkd      = 1'b1;
            ctrl.src_reg_is_rd = 1'b1;
        end
        F_BL, F_JIRL: begin
            // link value is pc+4, bl always links to r1
            ctrl.need_rj    = (fmt == F_JIRL);
            ctrl.src1_is_pc = 1'b1;
            ctrl.src2_is_4  = 1'b1;
            ctrl.gr_we      = 1'b1;
            ctrl.dest       = (fmt == F_BL) ? 5'd1 : rd;
        end
        default: ;
    endcase
end

endmodule

//--- common/id_pkg.sv
package id_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // 3R and shift by immediate, matched on inst[31:15]
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP_SRA_W  = 17'h00030;
    localparam logic [16:0] OP_SLLI_W = 17'h00081;
    localparam logic [16:0] OP_SRLI_W = 17'h00089;
    localparam logic [16:0] OP_SRAI_W = 17'h00091;

    // 2RI12, matched on inst[31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_SLTUI  = 10'h009;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_XORI   = 10'h00f;
    localparam logic [9:0] OP_LD_B   = 10'h0a0;
    localparam logic [9:0] OP_LD_H   = 10'h0a1;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_B   = 10'h0a4;
    localparam logic [9:0] OP_ST_H   = 10'h0a5;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;
    localparam logic [9:0] OP_LD_BU  = 10'h0a8;
    localparam logic [9:0] OP_LD_HU  = 10'h0a9;

    // 1RI20, matched on inst[31:25]
    localparam logic [6:0] OP_LU12I_W   = 7'h0a;
    localparam logic [6:0] OP_PCADDU12I = 7'h0e;

    // branches, matched on inst[31:26]
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [5:0] OP_BLT  = 6'h18;
    localparam logic [5:0] OP_BGE  = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic            pred_taken;
        logic [XLEN-1:0] pred_target;
    } fetch_bundle_t;

    typedef struct packed {
        logic              en;
        logic              need_stall;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   data;
    } fwd_bus_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } wb_bus_t;

    // mem_size: 01 byte, 10 half, 00 word
    typedef struct packed {
        alu_op_e           alu_op;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              src2_is_4;
        logic              load;
        logic              store;
        logic [1:0]        mem_size;
        logic              mem_signed;
        logic              gr_we;
        logic [REG_AW-1:0] dest;
        logic              need_rj;
        logic              need_rkd;
        logic              src_reg_is_rd;
        br_kind_e          br_kind;
        logic              ine;
    } dec_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   rj_value;
        logic [XLEN-1:0]   rkd_value;
        alu_op_e           alu_op;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              src2_is_4;
        logic              load;
        logic              store;
        logic [1:0]        mem_size;
        logic              mem_signed;
        logic              gr_we;
        logic [REG_AW-1:0] dest;
        logic              ine;
    } ds_to_es_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage
